//--- src.f
+incdir+include
design/i3c_tx_pkg.sv
design/tti_queue.sv
design/width_converter_n_to_8.sv
design/descriptor_tx.sv
design/target_tx_serializer.sv
design/i3c_tx_top.sv
test/tb_clock_gen.sv
test/tb_i3c_tx.sv

//--- run.sh
#!/bin/sh
# Build the tx path testbench with Verilator, run it and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f src.f --top-module tb_i3c_tx
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_i3c_tx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- test/tb_i3c_tx.sv
// testbench for the tx path; messages stay within 16 bytes and ticks come at least 4 clocks apart.
`timescale 1ns/1ps
`default_nettype none

`include "i3c_tx_defines.svh"

module tb_i3c_tx;

  localparam int ClkPeriodNs = 100;
  localparam int MaxLen = 16;  // longest message in bytes, a power of two.
  localparam int MaxBits = MaxLen * 9;  // eight data bits and a T-bit per byte.
  localparam int FastGap = 4;  // clocks from one tick to the next.
  localparam int SlowGap = 25;
  localparam int NumMsgs = 16;  // reads issued over all tests.
  localparam int WatchdogNs = (NumMsgs * MaxLen * 9 * SlowGap + 1000) * ClkPeriodNs;

  typedef logic [MaxLen*8-1:0] msg_t;  // words back to back, so byte 0 sits in the low bits.

  logic clk;
  logic rst_n;
  logic desc_push;
  logic [31:0] desc_wdata;
  logic data_push;
  logic [31:0] data_wdata;
  logic read_req;
  logic scl_tick;
  logic bus_err;
  logic sda;
  logic sda_valid;
  logic ack;
  logic nack;
  logic done;
  logic desc_full;
  logic data_full;
  integer seed = 77603;  // $random state.
  string test_name = "idle";
  logic [MaxBits-1:0] exp_stream = '0;  // expected bits, first one in bit 0.
  int exp_nbits = 0;
  int exp_base = 0;  // bit_total when the current message started.
  int bit_total = 0;  // bits seen on sda since reset.
  int done_count = 0;

  tb_clock_gen #(.PeriodNs(ClkPeriodNs), .ResetCycles(5)) u_clock_gen (
    .clk_o(clk), .rst_no(rst_n)
  );

  i3c_tx_top dut0 (
    .clk_i(clk), .rst_ni(rst_n), .desc_push_i(desc_push), .desc_wdata_i(desc_wdata),
    .data_push_i(data_push), .data_wdata_i(data_wdata), .read_req_i(read_req),
    .scl_tick_i(scl_tick), .bus_err_i(bus_err), .sda_o(sda), .sda_valid_o(sda_valid),
    .ack_o(ack), .nack_o(nack), .done_o(done), .desc_full_o(desc_full),
    .data_full_o(data_full)
  );

  // **************************************************
  // reference model and checking
  // **************************************************
  function automatic logic [MaxBits-1:0] ref_stream(input int len, input msg_t msg);
    logic [MaxBits-1:0] stream;
    int k;
    stream = '0;
    k = 0;
    for (int i = 0; i < len; i++) begin
      for (int j = 7; j >= 0; j--) begin
        stream[k] = msg[i*8 + j];  // data bits go out msb first.
        k++;
      end
      stream[k] = (i != len - 1);  // T-bit, low only on the last byte.
      k++;
    end
    return stream;
  endfunction

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("Error %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  always @(negedge clk) begin : collect_bits
    int idx;
    idx = bit_total - exp_base;  // position inside the current message.
    if (sda_valid === 1'b1) begin
      if (idx >= exp_nbits) begin
        stop_on_failure($sformatf("unexpected bit on sda during %s", test_name));
      end else begin
        compare_values($sformatf("%s bit %0d", test_name, idx), 32'(exp_stream[idx]), 32'(sda));
        bit_total = bit_total + 1;
        idx = idx + 1;
      end
    end
    if (done === 1'b1) begin
      // done comes together with the T-bit of the last byte.
      compare_values({test_name, " bits at done"}, 32'(exp_nbits), 32'(idx));
      done_count = done_count + 1;
    end
  end

  initial begin
    #(WatchdogNs);
    stop_on_failure("timeout: the watchdog expired before all tests finished");
  end

  // **************************************************
  // stimulus helpers
  // **************************************************
  function automatic msg_t random_msg();
    msg_t m;
    for (int i = 0; i < MaxLen / 4; i++) begin
      m[i*32 +: 32] = $random(seed);
    end
    return m;
  endfunction

  task automatic push_descriptor(input int len);
    @(posedge clk);
    desc_push <= 1'b1;
    desc_wdata <= {16'($random(seed)), 16'(len)};  // reserved bits carry noise.
    @(posedge clk);
    desc_push <= 1'b0;
  endtask

  task automatic push_words(input msg_t msg, input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      @(posedge clk);
      data_push <= 1'b1;
      data_wdata <= msg[i*32 +: 32];
    end
    @(posedge clk);
    data_push <= 1'b0;
  endtask

  task automatic queue_message(input int len, input msg_t msg);
    push_descriptor(len);
    push_words(msg, 0, (len + 3) / 4);  // whole words, the tail bytes are padding.
  endtask

  task automatic expect_message(input string name, input int len, input msg_t msg);
    test_name = name;
    exp_stream = ref_stream(len, msg);
    exp_nbits = 9 * len;
    exp_base = bit_total;
  endtask

  task automatic tick_once(input int gap);
    @(posedge clk);
    scl_tick <= 1'b1;
    @(posedge clk);
    scl_tick <= 1'b0;
    repeat (gap - 2) @(posedge clk);
  endtask

  task automatic issue_read(output logic acked);
    @(posedge clk);
    read_req <= 1'b1;
    @(posedge clk);
    read_req <= 1'b0;
    @(negedge clk);  // the answer comes one cycle after the request.
    acked = 1'b0;
    if (ack === 1'b1) begin
      acked = 1'b1;
    end else if (nack !== 1'b1) begin
      stop_on_failure($sformatf("no ACK or NACK after a read request in %s", test_name));
    end
  endtask

  task automatic read_until_ack();
    logic acked;
    int tries;
    acked = 1'b0;
    tries = 0;
    while (!acked && tries < 100) begin
      issue_read(acked);
      tries++;
      if (!acked) begin
        repeat (4) @(posedge clk);  // message not started yet.
      end
    end
    if (!acked) begin
      stop_on_failure($sformatf("read for %s was never acknowledged", test_name));
    end
  endtask

  task automatic send_ticks(input int gap, input int abort_at);
    int done_base;
    logic aborted;
    done_base = done_count;
    aborted = 1'b0;
    while (done_count == done_base && !aborted) begin
      if (abort_at > 0 && bit_total - exp_base >= abort_at) begin
        @(posedge clk);
        bus_err <= 1'b1;
        @(posedge clk);
        bus_err <= 1'b0;
        aborted = 1'b1;
      end else begin
        tick_once(gap);
      end
    end
  endtask

  task automatic run_message(input string name, input int len, input msg_t msg,
                             input int gap, input int abort_at);
    expect_message(name, len, msg);
    read_until_ack();
    send_ticks(gap, abort_at);
  endtask

  // **************************************************
  // test sequence
  // **************************************************
  initial begin
    logic acked;
    int len;
    msg_t msg_a;
    msg_t msg_b;
    msg_t queued [3];
    int queued_len [3];
    desc_push <= 1'b0;
    desc_wdata <= '0;
    data_push <= 1'b0;
    data_wdata <= '0;
    read_req <= 1'b0;
    scl_tick <= 1'b0;
    bus_err <= 1'b0;
    wait (rst_n === 1'b1);

    test_name = "early read";
    issue_read(acked);
    compare_values("early read ack", 32'd0, 32'(acked));
    repeat (9) tick_once(FastGap);  // any bit here is caught by the collector.

    for (int n = 1; n <= 8; n++) begin
      msg_a = random_msg();
      queue_message(n, msg_a);
      run_message($sformatf("length %0d", n), n, msg_a, FastGap, 0);
    end

    msg_a = random_msg();
    push_descriptor(8);
    push_words(msg_a, 0, 1);  // second word is still missing.
    expect_message("data after descriptor nack", 0, msg_a);
    issue_read(acked);
    compare_values("data after descriptor ack", 32'd0, 32'(acked));
    push_words(msg_a, 1, 1);
    run_message("data after descriptor", 8, msg_a, FastGap, 0);

    for (int i = 0; i < 3; i++) begin
      queued_len[i] = 1 + ($random(seed) & (MaxLen - 1));
      queued[i] = random_msg();
      queue_message(queued_len[i], queued[i]);
    end
    for (int i = 0; i < 3; i++) begin
      run_message($sformatf("back to back %0d", i), queued_len[i], queued[i], FastGap, 0);
    end

    len = 1 + ($random(seed) & (MaxLen - 1));
    msg_a = random_msg();
    msg_b = random_msg();
    queue_message(12, msg_a);
    queue_message(len, msg_b);
    run_message("bus error", 12, msg_a, FastGap, 30);  // abort inside the fourth byte.
    run_message("after bus error", len, msg_b, FastGap, 0);

    msg_a = random_msg();
    queue_message(8, msg_a);
    run_message("slow ticks", 8, msg_a, SlowGap, 0);

    test_name = "queue full";
    msg_a = random_msg();
    for (int i = 0; i <= `TX_DATA_DEPTH; i++) begin  // the converter holds the first word.
      push_words(msg_a, i % 4, 1);
      @(negedge clk);
      compare_values("data queue full", 32'(i >= `TX_DATA_DEPTH), 32'(data_full));
    end
    for (int i = 0; i <= `TX_DESC_DEPTH; i++) begin  // the handler holds the first one.
      push_descriptor(4);
      @(negedge clk);
      compare_values("descriptor queue full", 32'(i >= `TX_DESC_DEPTH), 32'(desc_full));
    end

    repeat (10) @(posedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// simulation only clock and reset source; reset is released on a rising edge after ResetCycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PeriodNs = 100,  // clock period in ns.
  parameter int ResetCycles = 5  // rising edges with reset held low.
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;  // known level from time zero.
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;  // reset is active from the start.
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;  // flops leave reset on the next edge.
  end

endmodule

`default_nettype wire

//--- design/i3c_tx_top.sv
// top of the target tx path; the descriptor queue depth is not used by the handler.
`timescale 1ns/1ps
`default_nettype none

`include "i3c_tx_defines.svh"

module i3c_tx_top (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic desc_push_i,
  input  i3c_tx_pkg::tx_desc_t desc_wdata_i,
  input  logic data_push_i,
  input  i3c_tx_pkg::tx_word_t data_wdata_i,
  input  logic read_req_i,
  input  logic scl_tick_i,
  input  logic bus_err_i,
  output logic sda_o,
  output logic sda_valid_o,
  output logic ack_o,
  output logic nack_o,
  output logic done_o,
  output logic desc_full_o,
  output logic data_full_o
);

  import i3c_tx_pkg::*;

  logic desc_rvalid;
  logic desc_rready;
  tx_desc_t desc_rdata;
  logic word_valid;
  logic word_ready;
  tx_word_t word;
  logic [$clog2(`TX_DATA_DEPTH+1)-1:0] data_depth;
  logic conv_byte_valid;
  logic conv_byte_ready;
  tx_byte_t conv_byte;
  logic conv_flush;
  logic conv_occupied;
  tx_byte_t tx_byte;
  logic tx_last;
  logic tx_valid;
  logic tx_ready;
  logic tx_err;

  tti_queue #(.payload_t(tx_desc_t), .DEPTH(`TX_DESC_DEPTH)) u_desc_queue (
    .clk_i, .rst_ni, .push_i(desc_push_i), .wdata_i(desc_wdata_i), .full_o(desc_full_o),
    .rvalid_o(desc_rvalid), .rready_i(desc_rready), .rdata_o(desc_rdata), .depth_o()
  );

  tti_queue #(.payload_t(tx_word_t), .DEPTH(`TX_DATA_DEPTH)) u_data_queue (
    .clk_i, .rst_ni, .push_i(data_push_i), .wdata_i(data_wdata_i), .full_o(data_full_o),
    .rvalid_o(word_valid), .rready_i(word_ready), .rdata_o(word), .depth_o(data_depth)
  );

  width_converter_n_to_8 u_conv (
    .clk_i, .rst_ni, .word_valid_i(word_valid), .word_ready_o(word_ready), .word_i(word),
    .byte_valid_o(conv_byte_valid), .byte_ready_i(conv_byte_ready), .byte_o(conv_byte),
    .flush_i(conv_flush), .occupied_o(conv_occupied)
  );

  descriptor_tx u_desc_tx (
    .clk_i, .rst_ni, .desc_rvalid_i(desc_rvalid), .desc_rready_o(desc_rready),
    .desc_rdata_i(desc_rdata), .data_depth_i(data_depth), .conv_occupied_i(conv_occupied),
    .conv_byte_valid_i(conv_byte_valid), .conv_byte_ready_o(conv_byte_ready),
    .conv_byte_i(conv_byte), .conv_flush_o(conv_flush), .tx_byte_o(tx_byte),
    .tx_byte_last_o(tx_last), .tx_byte_valid_o(tx_valid), .tx_byte_ready_i(tx_ready),
    .tx_byte_err_i(tx_err)
  );

  target_tx_serializer u_ser (
    .clk_i, .rst_ni, .read_req_i, .scl_tick_i, .bus_err_i, .byte_i(tx_byte),
    .byte_last_i(tx_last), .byte_valid_i(tx_valid), .byte_ready_o(tx_ready),
    .byte_err_o(tx_err), .sda_o, .sda_valid_o, .ack_o, .nack_o, .done_o
  );

endmodule

`default_nettype wire

//--- design/target_tx_serializer.sv
// private read responder; needs at least three clocks between scl ticks to refill bytes.
`timescale 1ns/1ps
`default_nettype none

module target_tx_serializer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic read_req_i,
  input  logic scl_tick_i,
  input  logic bus_err_i,
  input  i3c_tx_pkg::tx_byte_t byte_i,
  input  logic byte_last_i,
  input  logic byte_valid_i,
  output logic byte_ready_o,
  output logic byte_err_o,
  output logic sda_o,
  output logic sda_valid_o,
  output logic ack_o,
  output logic nack_o,
  output logic done_o
);

  import i3c_tx_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    Ack,
    Shift
  } state_e;

  state_e state_q;
  logic [3:0] bit_cnt_q;  // 0..7 data bits, 8 is the T-bit.
  tx_byte_t shift_q;  // remaining data bits, msb next.
  logic tick;
  logic first_bit;
  logic data_bit;

  assign tick = (state_q == Shift) && scl_tick_i && !bus_err_i;  // an error wins.
  assign first_bit = tick && (bit_cnt_q == 4'd0) && byte_valid_i;  // waits for a byte.
  assign data_bit = tick && (bit_cnt_q inside {[4'd1:4'd7]});
  assign byte_ready_o = tick && (bit_cnt_q == 4'd8);  // ninth tick takes the byte.
  assign byte_err_o = bus_err_i && (state_q != Idle);  // only a running read aborts.
  assign ack_o = state_q == Ack;  // one cycle after the request.

  // **************************************************
  // control FSM and bit output
  // **************************************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      bit_cnt_q <= '0;
      sda_o <= 1'b0;
      sda_valid_o <= 1'b0;
      nack_o <= 1'b0;
      done_o <= 1'b0;
    end else begin
      sda_valid_o <= first_bit || data_bit || byte_ready_o;
      nack_o <= read_req_i && (state_q == Idle) && !byte_valid_i;  // no message ready.
      done_o <= byte_ready_o && byte_last_i;
      if (first_bit) begin
        sda_o <= byte_i[7];
      end else if (data_bit) begin
        sda_o <= shift_q[7];
      end else if (byte_ready_o) begin
        sda_o <= ~byte_last_i;  // T-bit is 1 while more bytes follow.
      end
      unique case (state_q)
        Idle: begin
          if (read_req_i && byte_valid_i) begin
            state_q <= Ack;
          end
        end
        Ack: begin
          bit_cnt_q <= '0;
          state_q <= bus_err_i ? Idle : Shift;
        end
        Shift: begin
          if (bus_err_i) begin
            state_q <= Idle;
          end else if (first_bit || data_bit) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end else if (byte_ready_o) begin
            bit_cnt_q <= '0;
            if (byte_last_i) begin
              state_q <= Idle;  // message complete.
            end
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (first_bit) begin
      shift_q <= {byte_i[6:0], 1'b0};
    end else if (data_bit) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  // a byte is taken only while the handler still offers it.
  a_ready_tbit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    byte_ready_o |-> byte_valid_i);

endmodule

`default_nettype wire

//--- design/descriptor_tx.sv
// tx descriptor handler; a length of zero is not supported and all data must fit the queue.
`timescale 1ns/1ps
`default_nettype none

`include "i3c_tx_defines.svh"

module descriptor_tx (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic desc_rvalid_i,
  output logic desc_rready_o,
  input  i3c_tx_pkg::tx_desc_t desc_rdata_i,
  input  logic [$clog2(`TX_DATA_DEPTH+1)-1:0] data_depth_i,
  input  logic conv_occupied_i,
  input  logic conv_byte_valid_i,
  output logic conv_byte_ready_o,
  input  i3c_tx_pkg::tx_byte_t conv_byte_i,
  output logic conv_flush_o,
  output i3c_tx_pkg::tx_byte_t tx_byte_o,
  output logic tx_byte_last_o,
  output logic tx_byte_valid_o,
  input  logic tx_byte_ready_i,
  input  logic tx_byte_err_i
);

  import i3c_tx_pkg::*;

  localparam int unsigned LenW = `TX_LEN_W;
  localparam int unsigned SumW = LenW + 1;  // room for the round-up carry.
  localparam int unsigned WordShift = $clog2(`TX_WORD_W / 8);

  tx_desc_t desc_q;  // descriptor of the current message.
  logic desc_valid_q;  // desc_q holds a descriptor.
  logic pending_q;  // message started and not yet finished.
  logic drain_q;  // discarding the rest after a bus error.
  logic [LenW-1:0] byte_cnt_q;  // bytes still to leave.
  logic [SumW-1:0] words_needed;
  logic [SumW-1:0] words_avail;
  logic tx_start;
  logic msg_end;

  // **************************************************
  // descriptor capture and start condition
  // **************************************************
  assign desc_rready_o = !desc_valid_q && desc_rvalid_i;  // one descriptor at a time.
  assign words_needed = ({1'b0, desc_q.len} + SumW'(`TX_WORD_W / 8 - 1)) >> WordShift;
  assign words_avail = SumW'(data_depth_i) + SumW'(conv_occupied_i);
  assign tx_start = !pending_q && desc_valid_q && (words_avail >= words_needed);

  // **************************************************
  // byte path
  // **************************************************
  assign tx_byte_o = conv_byte_i;
  assign tx_byte_valid_o = pending_q && !drain_q && conv_byte_valid_i;
  assign tx_byte_last_o = pending_q && !drain_q && (byte_cnt_q == LenW'(1));
  assign conv_byte_ready_o = (tx_byte_valid_o && tx_byte_ready_i) ||
                             (drain_q && conv_byte_valid_i);  // drain one byte per cycle.
  assign msg_end = conv_byte_ready_o && (byte_cnt_q == LenW'(1));
  assign conv_flush_o = msg_end;  // drops the unused tail of the last word.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_valid_q <= 1'b0;
      pending_q <= 1'b0;
      drain_q <= 1'b0;
      byte_cnt_q <= '0;
    end else begin
      if (desc_rready_o) begin
        desc_valid_q <= 1'b1;
      end else if (msg_end) begin
        desc_valid_q <= 1'b0;  // next descriptor can be taken next cycle.
      end
      if (tx_start) begin
        pending_q <= 1'b1;
        byte_cnt_q <= desc_q.len;  // whole message is queued now.
      end else begin
        if (msg_end) begin
          pending_q <= 1'b0;
        end
        if (conv_byte_ready_o) begin
          byte_cnt_q <= byte_cnt_q - 1'b1;
        end
      end
      if (msg_end) begin
        drain_q <= 1'b0;
      end else if (pending_q && tx_byte_err_i) begin
        drain_q <= 1'b1;  // serializer aborted the read.
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_rready_o) begin
      desc_q <= desc_rdata_i;
    end
  end

  // a byte is only offered for a captured message with bytes left in it.
  a_valid_pending : assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_o |-> desc_valid_q && byte_cnt_q != '0);

  // the accepted last byte ends the message and the flush empties the converter.
  a_last_count : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tx_byte_last_o && conv_byte_ready_o) |=> !pending_q && !conv_byte_valid_i);

endmodule

`default_nettype wire

//--- design/width_converter_n_to_8.sv
// unpacks one word into bytes, low byte first; a flush drops the unused bytes of the word.
`timescale 1ns/1ps
`default_nettype none

`include "i3c_tx_defines.svh"

module width_converter_n_to_8 (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic word_valid_i,
  output logic word_ready_o,
  input  i3c_tx_pkg::tx_word_t word_i,
  output logic byte_valid_o,
  input  logic byte_ready_i,
  output i3c_tx_pkg::tx_byte_t byte_o,
  input  logic flush_i,
  output logic occupied_o
);

  import i3c_tx_pkg::*;

  localparam int unsigned Bpw = `TX_WORD_W / 8;  // bytes per word.
  localparam int unsigned IdxW = $clog2(Bpw);

  tx_word_t word_q;  // word being unpacked.
  logic [IdxW-1:0] idx_q;  // next byte to present.
  logic held_q;  // a word is loaded.
  logic load;
  logic advance;

  assign word_ready_o = !held_q;  // only an empty converter takes a word.
  assign load = word_valid_i && word_ready_o;
  assign byte_valid_o = held_q;
  assign occupied_o = held_q;  // counts as one word toward the start condition.
  assign byte_o = word_q[idx_q*8 +: 8];
  assign advance = held_q && byte_ready_i;  // the byte is consumed this cycle.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
      idx_q <= '0;
    end else begin
      if (load) begin
        held_q <= 1'b1;  // byte 0 is visible next cycle.
        idx_q <= '0;
      end else if (flush_i || (advance && idx_q == IdxW'(Bpw - 1))) begin
        held_q <= 1'b0;  // end of word or end of message.
        idx_q <= '0;
      end else if (advance) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      word_q <= word_i;
    end
  end

  // the handler flushes only while it takes a held byte, never on an empty converter.
  a_flush_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> held_q && byte_ready_i && !load);

endmodule

`default_nettype wire

//--- design/tti_queue.sv
// fifo for any payload; DEPTH must be a power of two, and a push to a full queue is dropped.
`timescale 1ns/1ps
`default_nettype none

module tti_queue #(
  parameter type payload_t = logic [31:0],
  parameter int unsigned DEPTH = 4,
  localparam int unsigned PtrW = $clog2(DEPTH),
  localparam int unsigned CntW = $clog2(DEPTH + 1)
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  payload_t wdata_i,
  output logic full_o,
  output logic rvalid_o,
  input  logic rready_i,
  output payload_t rdata_o,
  output logic [CntW-1:0] depth_o
);

  payload_t mem [DEPTH];   // storage array.
  logic [PtrW-1:0] wr_ptr_q;  // next slot to write.
  logic [PtrW-1:0] rd_ptr_q;  // oldest stored entry.
  logic [CntW-1:0] count_q;   // number of stored entries.
  logic do_push;
  logic do_pop;

  assign full_o = count_q == CntW'(DEPTH);  // no room left.
  assign rvalid_o = count_q != '0;  // independent of rready_i.
  assign rdata_o = mem[rd_ptr_q];  // head of the queue.
  assign depth_o = count_q;
  assign do_push = push_i && !full_o;  // writes to a full queue are lost.
  assign do_pop = rvalid_o && rready_i;  // valid/ready handshake.

  // **************************************************
  // pointers and occupancy
  // **************************************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps naturally at DEPTH.
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= wdata_i;  // entry shows on rvalid_o next cycle.
    end
  end

  // the count must track pushes and pops without running past the array.
  a_depth_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    depth_o <= CntW'(DEPTH));

endmodule

`default_nettype wire

//--- design/i3c_tx_pkg.sv
// shared tx types; the descriptor is 32 bits and only its length field is interpreted.
`default_nettype none

`include "i3c_tx_defines.svh"

package i3c_tx_pkg;

  typedef logic [7:0] tx_byte_t;  // one byte as it goes out on the bus.

  typedef logic [`TX_WORD_W-1:0] tx_word_t;  // byte 0 is in bits 7:0 and goes out first.

  typedef struct packed {
    logic [31:`TX_LEN_W] rsvd;  // reserved bits, ignored by the handler.
    logic [`TX_LEN_W-1:0] len;  // message length in bytes, never zero.
  } tx_desc_t;

endpackage

`default_nettype wire

//--- include/i3c_tx_defines.svh
// sizes for the tx path; depths must be powers of two and the word a whole number of bytes.
`ifndef I3C_TX_DEFINES_SVH
`define I3C_TX_DEFINES_SVH

// **************************************************
// queue sizes
// **************************************************
`define TX_DESC_DEPTH 4   // descriptor queue entries.
`define TX_DATA_DEPTH 16  // data queue entries, one word each.

// **************************************************
// field widths
// **************************************************
`define TX_WORD_W 32  // data word width in bits.
`define TX_LEN_W 16   // byte length field in the low bits of a descriptor.

`endif
